// File: hw/predecode_pkg.sv
// LoongArch32 subset only: 37 integer, branch and load/store encodings
// no multiply/divide; every unlisted encoding decodes to an empty class
package predecode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      inst_t;
    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // bl writes the return address here
    localparam reg_idx_t LINK_REG = 5'd1;

    ////////////////////////////////////////
    // opcodes, each sized to its field

    // inst[31:15], three-register and immediate shifts
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002e;
    localparam logic [16:0] OPC_SRL_W  = 17'h0002f;
    localparam logic [16:0] OPC_SRA_W  = 17'h00030;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;
    // inst[31:22], 12-bit immediate forms and memory
    localparam logic [9:0]  OPC_SLTI   = 10'h008;
    localparam logic [9:0]  OPC_SLTUI  = 10'h009;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_ANDI   = 10'h00d;
    localparam logic [9:0]  OPC_ORI    = 10'h00e;
    localparam logic [9:0]  OPC_XORI   = 10'h00f;
    localparam logic [9:0]  OPC_LD_B   = 10'h0a0;
    localparam logic [9:0]  OPC_LD_H   = 10'h0a1;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_B   = 10'h0a4;
    localparam logic [9:0]  OPC_ST_H   = 10'h0a5;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
    // inst[31:25], si20 forms
    localparam logic [6:0]  OPC_LU12I_W   = 7'h0a;
    localparam logic [6:0]  OPC_PCADDU12I = 7'h0e;
    // inst[31:26], jumps and branches
    localparam logic [5:0]  OPC_JIRL = 6'h13;
    localparam logic [5:0]  OPC_B    = 6'h14;
    localparam logic [5:0]  OPC_BL   = 6'h15;
    localparam logic [5:0]  OPC_BEQ  = 6'h16;
    localparam logic [5:0]  OPC_BNE  = 6'h17;
    localparam logic [5:0]  OPC_BLT  = 6'h18;
    localparam logic [5:0]  OPC_BGE  = 6'h19;
    localparam logic [5:0]  OPC_BLTU = 6'h1a;
    localparam logic [5:0]  OPC_BGEU = 6'h1b;

    ////////////////////////////////////////
    // selector encodings

    typedef enum logic [1:0] {SRC1_ZERO, SRC1_REGFILE, SRC1_PC} src1_sel_t;
    typedef enum logic [1:0] {SRC2_ZERO, SRC2_REGFILE, SRC2_IMM, SRC2_FOUR} src2_sel_t;
    typedef enum logic [1:0] {MEM_WORD, MEM_HALF, MEM_BYTE} mem_width_t;
    // first stage where the write-back value can be bypassed
    typedef enum logic [1:0] {STAGE_NONE, STAGE_EXE, STAGE_MEM} ready_stage_t;

    ////////////////////////////////////////
    // bundles

    // one flag per instruction, msb first; _r marks the register logic ops
    typedef struct packed {
        logic addi_w, add_w, sub_w, or_r, ori, nor_r, andi, and_r, xor_r, xori;
        logic srl_w, srli_w, sll_w, slli_w, sra_w, srai_w;
        logic lu12i_w, pcaddu12i, slt, slti, sltu, sltui;
        logic jirl, b, beq, bne, bge, bgeu, bl, blt, bltu;
        logic st_w, ld_w, st_h, ld_h, st_b, ld_b;
    } inst_class_t;

    typedef struct packed {
        addr_t pc;
        addr_t pred_pc;
        inst_t inst;
    } fetch_bundle_t;

    typedef struct packed {
        reg_idx_t r_addr1;
        reg_idx_t r_addr2;
        reg_idx_t w_addr;
    } regnums_t;

    // one-hot alu function
    typedef struct packed {
        logic lui, sra, srl, sll, xor_op, or_op, nor_op, and_op, sltu, slt, sub, add;
    } alu_op_t;

    typedef struct packed {
        logic       en;
        logic       we;
        mem_width_t width;
    } mem_ctrl_t;

    typedef struct packed {
        logic         w_en;
        logic         from_mem;
        ready_stage_t ready_stage;
    } wb_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
    } exe_ctrl_t;

    typedef struct packed {
        addr_t       pc;
        addr_t       pred_pc;
        inst_class_t inst_class;
        regnums_t    regnums;
        logic [31:0] imm;
        exe_ctrl_t   exe;
        mem_ctrl_t   mem;
        wb_ctrl_t    wb;
    } predecoded_t;

    ////////////////////////////////////////
    // instruction groups, shared by the decoders

    // three-register alu ops
    function automatic logic is_rr(input inst_class_t c);
        return c.add_w | c.sub_w | c.slt | c.sltu | c.nor_r | c.and_r | c.or_r
             | c.xor_r | c.sll_w | c.srl_w | c.sra_w;
    endfunction

    // rj op immediate
    function automatic logic is_imm_op(input inst_class_t c);
        return c.addi_w | c.slti | c.sltui | c.andi | c.ori | c.xori
             | c.slli_w | c.srli_w | c.srai_w;
    endfunction

    function automatic logic is_cond_br(input inst_class_t c);
        return c.beq | c.bne | c.blt | c.bge | c.bltu | c.bgeu;
    endfunction

    function automatic logic is_load(input inst_class_t c);
        return c.ld_w | c.ld_h | c.ld_b;
    endfunction

    function automatic logic is_store(input inst_class_t c);
        return c.st_w | c.st_h | c.st_b;
    endfunction

    // everything that writes rd; bl is separate, it writes LINK_REG
    function automatic logic writes_rd(input inst_class_t c);
        return is_rr(c) | is_imm_op(c) | c.lu12i_w | c.pcaddu12i | c.jirl | is_load(c);
    endfunction

endpackage

// File: hw/inst_classifier.sv
// flags are one-hot for the 37 known encodings, all zero for anything else
module inst_classifier (
    input  predecode_pkg::inst_t       inst,
    output predecode_pkg::inst_class_t inst_class
);
    import predecode_pkg::*;

    // opcode fields, all left-aligned at bit 31
    logic [5:0]  opc6;
    logic [6:0]  opc7;
    logic [9:0]  opc10;
    logic [16:0] opc17;

    assign opc6  = inst[31:26];
    assign opc7  = inst[31:25];
    assign opc10 = inst[31:22];
    assign opc17 = inst[31:15];

    ////////////////////////////////////////
    // alu, register forms
    assign inst_class.add_w  = (opc17 == OPC_ADD_W);
    assign inst_class.sub_w  = (opc17 == OPC_SUB_W);
    assign inst_class.slt    = (opc17 == OPC_SLT);
    assign inst_class.sltu   = (opc17 == OPC_SLTU);
    assign inst_class.nor_r  = (opc17 == OPC_NOR);
    assign inst_class.and_r  = (opc17 == OPC_AND);
    assign inst_class.or_r   = (opc17 == OPC_OR);
    assign inst_class.xor_r  = (opc17 == OPC_XOR);
    assign inst_class.sll_w  = (opc17 == OPC_SLL_W);
    assign inst_class.srl_w  = (opc17 == OPC_SRL_W);
    assign inst_class.sra_w  = (opc17 == OPC_SRA_W);
    // shift by ui5, still a 17-bit opcode
    assign inst_class.slli_w = (opc17 == OPC_SLLI_W);
    assign inst_class.srli_w = (opc17 == OPC_SRLI_W);
    assign inst_class.srai_w = (opc17 == OPC_SRAI_W);

    ////////////////////////////////////////
    // 12-bit immediate forms
    assign inst_class.slti   = (opc10 == OPC_SLTI);
    assign inst_class.sltui  = (opc10 == OPC_SLTUI);
    assign inst_class.addi_w = (opc10 == OPC_ADDI_W);
    assign inst_class.andi   = (opc10 == OPC_ANDI);
    assign inst_class.ori    = (opc10 == OPC_ORI);
    assign inst_class.xori   = (opc10 == OPC_XORI);

    // si20 forms
    assign inst_class.lu12i_w   = (opc7 == OPC_LU12I_W);
    assign inst_class.pcaddu12i = (opc7 == OPC_PCADDU12I);

    ////////////////////////////////////////
    // jumps and branches
    assign inst_class.jirl = (opc6 == OPC_JIRL);
    assign inst_class.b    = (opc6 == OPC_B);
    assign inst_class.bl   = (opc6 == OPC_BL);
    assign inst_class.beq  = (opc6 == OPC_BEQ);
    assign inst_class.bne  = (opc6 == OPC_BNE);
    assign inst_class.blt  = (opc6 == OPC_BLT);
    assign inst_class.bge  = (opc6 == OPC_BGE);
    assign inst_class.bltu = (opc6 == OPC_BLTU);
    assign inst_class.bgeu = (opc6 == OPC_BGEU);

    ////////////////////////////////////////
    // loads and stores
    assign inst_class.ld_b = (opc10 == OPC_LD_B);
    assign inst_class.ld_h = (opc10 == OPC_LD_H);
    assign inst_class.ld_w = (opc10 == OPC_LD_W);
    assign inst_class.st_b = (opc10 == OPC_ST_B);
    assign inst_class.st_h = (opc10 == OPC_ST_H);
    assign inst_class.st_w = (opc10 == OPC_ST_W);

endmodule

// File: hw/regnum_select.sv
// register numbers for an unused port are zero
module regnum_select (
    input  predecode_pkg::inst_t       inst,
    input  predecode_pkg::inst_class_t inst_class,
    output predecode_pkg::regnums_t    regnums
);
    import predecode_pkg::*;

    reg_idx_t rk;
    reg_idx_t rj;
    reg_idx_t rd;
    logic     rj_first;
    logic     rd_second;

    assign rk = inst[14:10];
    assign rj = inst[9:5];
    assign rd = inst[4:0];

    // rj on port 1 unless the op reads rk and rj
    assign rj_first = is_imm_op(inst_class) | inst_class.jirl | is_cond_br(inst_class)
                    | is_load(inst_class) | is_store(inst_class);
    // rd is a source for compares and store data
    assign rd_second = is_cond_br(inst_class) | is_store(inst_class);

    always_comb
    begin
        // port 1
        if (is_rr(inst_class))
            regnums.r_addr1 = rk;
        else if (rj_first)
            regnums.r_addr1 = rj;
        else
            regnums.r_addr1 = '0;

        // port 2
        if (is_rr(inst_class))
            regnums.r_addr2 = rj;
        else if (rd_second)
            regnums.r_addr2 = rd;
        else
            regnums.r_addr2 = '0;

        // write port, bl links through r1
        if (writes_rd(inst_class))
            regnums.w_addr = rd;
        else if (inst_class.bl)
            regnums.w_addr = LINK_REG;
        else
            regnums.w_addr = '0;
    end

endmodule

// File: hw/imm_gen.sv
// six immediate formats, zero for instructions without one
module imm_gen (
    input  predecode_pkg::inst_t       inst,
    input  predecode_pkg::inst_class_t inst_class,
    output logic [31:0]                imm
);
    import predecode_pkg::*;

    logic sel_si12;
    logic sel_ui12;
    logic sel_ui5;
    logic sel_si20;
    logic sel_offs16;
    logic sel_offs26;

    // format per instruction group
    assign sel_si12 = inst_class.addi_w | inst_class.slti | inst_class.sltui
                    | is_load(inst_class) | is_store(inst_class);
    assign sel_ui12   = inst_class.ori | inst_class.andi | inst_class.xori;
    assign sel_ui5    = inst_class.slli_w | inst_class.srli_w | inst_class.srai_w;
    assign sel_si20   = inst_class.lu12i_w | inst_class.pcaddu12i;
    assign sel_offs16 = inst_class.jirl | is_cond_br(inst_class);
    assign sel_offs26 = inst_class.b | inst_class.bl;

    // groups never overlap, so the order here is arbitrary
    always_comb
    begin
        if (sel_si12)
            imm = {{20{inst[21]}}, inst[21:10]};
        else if (sel_ui12)
            imm = {20'd0, inst[21:10]};
        else if (sel_ui5)
            imm = {27'd0, inst[14:10]};
        else if (sel_si20)
            imm = {inst[24:5], 12'd0};
        else if (sel_offs16)
            imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        // offs26 is split: high 10 bits sit in inst[9:0]
        else if (sel_offs26)
            imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        else
            imm = '0;
    end

endmodule

// File: hw/ctrl_gen.sv
// exe, mem and wb controls; an unknown encoding is idle with src1 on regfile
module ctrl_gen (
    input  predecode_pkg::inst_class_t inst_class,
    output predecode_pkg::exe_ctrl_t   exe,
    output predecode_pkg::mem_ctrl_t   mem,
    output predecode_pkg::wb_ctrl_t    wb
);
    import predecode_pkg::*;

    logic load;
    logic store;
    logic writer;

    assign load   = is_load(inst_class);
    assign store  = is_store(inst_class);
    // bl counts, it writes the link register
    assign writer = writes_rd(inst_class) | inst_class.bl;

    ////////////////////////////////////////
    // alu function, reg and imm forms share one flag
    assign exe.alu_op.lui    = inst_class.lu12i_w;
    assign exe.alu_op.sra    = inst_class.sra_w | inst_class.srai_w;
    assign exe.alu_op.srl    = inst_class.srl_w | inst_class.srli_w;
    assign exe.alu_op.sll    = inst_class.sll_w | inst_class.slli_w;
    assign exe.alu_op.xor_op = inst_class.xor_r | inst_class.xori;
    assign exe.alu_op.or_op  = inst_class.or_r | inst_class.ori;
    assign exe.alu_op.nor_op = inst_class.nor_r;
    assign exe.alu_op.and_op = inst_class.and_r | inst_class.andi;
    assign exe.alu_op.sltu   = inst_class.sltu | inst_class.sltui;
    assign exe.alu_op.slt    = inst_class.slt | inst_class.slti;
    assign exe.alu_op.sub    = inst_class.sub_w;
    // address calc and pc + 4 link go through the adder as well
    assign exe.alu_op.add    = inst_class.addi_w | inst_class.add_w | inst_class.jirl
                             | inst_class.bl | load | store | inst_class.pcaddu12i;

    ////////////////////////////////////////
    // operand sources
    always_comb
    begin
        if (inst_class.pcaddu12i | inst_class.bl)
            exe.src1_sel = SRC1_PC;
        // ordered branches leave the alu unused
        else if (inst_class.lu12i_w | inst_class.b | inst_class.bge | inst_class.bgeu
                 | inst_class.blt | inst_class.bltu)
            exe.src1_sel = SRC1_ZERO;
        else
            exe.src1_sel = SRC1_REGFILE;
    end

    always_comb
    begin
        if (inst_class.bl)
            exe.src2_sel = SRC2_FOUR;
        else if (is_rr(inst_class) | inst_class.beq | inst_class.bne)
            exe.src2_sel = SRC2_REGFILE;
        else if (is_imm_op(inst_class) | inst_class.lu12i_w | inst_class.pcaddu12i
                 | inst_class.jirl | load | store)
            exe.src2_sel = SRC2_IMM;
        else
            exe.src2_sel = SRC2_ZERO;
    end

    ////////////////////////////////////////
    // data memory
    assign mem.en = load | store;
    assign mem.we = store;

    always_comb
    begin
        if (inst_class.ld_b | inst_class.st_b)
            mem.width = MEM_BYTE;
        else if (inst_class.ld_h | inst_class.st_h)
            mem.width = MEM_HALF;
        else
            mem.width = MEM_WORD;
    end

    ////////////////////////////////////////
    // write-back and bypass stage
    assign wb.w_en     = writer;
    assign wb.from_mem = load;

    always_comb
    begin
        if (load)
            wb.ready_stage = STAGE_MEM;
        else if (writer)
            wb.ready_stage = STAGE_EXE;
        else
            wb.ready_stage = STAGE_NONE;
    end

endmodule

// File: hw/predecode_stage.sv
// one-entry stage with valid/ready; decode is combinational from the held bundle
// no flush input, redirection is handled upstream
module predecode_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  predecode_pkg::fetch_bundle_t in_bundle,
    output logic                         out_valid,
    input  logic                         out_ready,
    output predecode_pkg::predecoded_t   out_data
);
    import predecode_pkg::*;

    fetch_bundle_t held;
    inst_class_t   inst_class;
    regnums_t      regnums;
    logic [31:0]   imm;
    exe_ctrl_t     exe;
    mem_ctrl_t     mem;
    wb_ctrl_t      wb;

    ////////////////////////////////////////
    // handshake

    // empty, or the held item leaves this cycle
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
            held      <= '0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
            // bundle only moves on an actual transfer
            if (in_valid)
                held <= in_bundle;
        end
    end

    ////////////////////////////////////////
    // decode

    inst_classifier u_classifier (
        .inst       (held.inst),
        .inst_class (inst_class)
    );

    regnum_select u_regnum (
        .inst       (held.inst),
        .inst_class (inst_class),
        .regnums    (regnums)
    );

    imm_gen u_imm (
        .inst       (held.inst),
        .inst_class (inst_class),
        .imm        (imm)
    );

    ctrl_gen u_ctrl (
        .inst_class (inst_class),
        .exe        (exe),
        .mem        (mem),
        .wb         (wb)
    );

    // pcs pass straight through
    assign out_data.pc         = held.pc;
    assign out_data.pred_pc    = held.pred_pc;
    assign out_data.inst_class = inst_class;
    assign out_data.regnums    = regnums;
    assign out_data.imm        = imm;
    assign out_data.exe        = exe;
    assign out_data.mem        = mem;
    assign out_data.wb         = wb;

endmodule

// File: include/predecode_model.svh
// reference decode for the testbench; include where predecode_pkg::* is imported
// rows follow the LoongArch32 encoding table, unknown words decode idle
`ifndef PREDECODE_MODEL_SVH
`define PREDECODE_MODEL_SVH

// kind codes
//   0 rr alu      1 si12 alu   2 ui12 alu   3 ui5 shift   4 lu12i.w
//   5 pcaddu12i   6 jirl       7 beq/bne    8 blt..bgeu   9 b
//  10 bl         11 load      12 store     15 unknown
// alu is the bit index in alu_op_t (15 none), cls the bit in inst_class_t
function automatic predecoded_t predecode_model(input fetch_bundle_t bundle);
    predecoded_t d;
    inst_t       i;
    logic [3:0]  kind;
    logic [3:0]  alu;
    logic [5:0]  cls;

    i = bundle.inst;
    {kind, alu, cls} = {4'd15, 4'd15, 6'd63};
    casez (i[31:15])
        // add sub slt sltu nor and or xor sll srl sra
        17'h00020: {kind, alu, cls} = {4'd0, 4'd0, 6'd35};
        17'h00022: {kind, alu, cls} = {4'd0, 4'd1, 6'd34};
        17'h00024: {kind, alu, cls} = {4'd0, 4'd2, 6'd18};
        17'h00025: {kind, alu, cls} = {4'd0, 4'd3, 6'd16};
        17'h00028: {kind, alu, cls} = {4'd0, 4'd5, 6'd31};
        17'h00029: {kind, alu, cls} = {4'd0, 4'd4, 6'd29};
        17'h0002a: {kind, alu, cls} = {4'd0, 4'd6, 6'd33};
        17'h0002b: {kind, alu, cls} = {4'd0, 4'd7, 6'd28};
        17'h0002e: {kind, alu, cls} = {4'd0, 4'd8, 6'd24};
        17'h0002f: {kind, alu, cls} = {4'd0, 4'd9, 6'd26};
        17'h00030: {kind, alu, cls} = {4'd0, 4'd10, 6'd22};
        // slli srli srai
        17'h00081: {kind, alu, cls} = {4'd3, 4'd8, 6'd23};
        17'h00089: {kind, alu, cls} = {4'd3, 4'd9, 6'd25};
        17'h00091: {kind, alu, cls} = {4'd3, 4'd10, 6'd21};
        // slti sltui addi.w, then andi ori xori
        17'b0000001000_???????: {kind, alu, cls} = {4'd1, 4'd2, 6'd17};
        17'b0000001001_???????: {kind, alu, cls} = {4'd1, 4'd3, 6'd15};
        17'b0000001010_???????: {kind, alu, cls} = {4'd1, 4'd0, 6'd36};
        17'b0000001101_???????: {kind, alu, cls} = {4'd2, 4'd4, 6'd30};
        17'b0000001110_???????: {kind, alu, cls} = {4'd2, 4'd6, 6'd32};
        17'b0000001111_???????: {kind, alu, cls} = {4'd2, 4'd7, 6'd27};
        // lu12i.w pcaddu12i
        17'b0001010_??????????: {kind, alu, cls} = {4'd4, 4'd11, 6'd20};
        17'b0001110_??????????: {kind, alu, cls} = {4'd5, 4'd0, 6'd19};
        // ld.b ld.h ld.w st.b st.h st.w
        17'b0010100000_???????: {kind, alu, cls} = {4'd11, 4'd0, 6'd0};
        17'b0010100001_???????: {kind, alu, cls} = {4'd11, 4'd0, 6'd2};
        17'b0010100010_???????: {kind, alu, cls} = {4'd11, 4'd0, 6'd4};
        17'b0010100100_???????: {kind, alu, cls} = {4'd12, 4'd0, 6'd1};
        17'b0010100101_???????: {kind, alu, cls} = {4'd12, 4'd0, 6'd3};
        17'b0010100110_???????: {kind, alu, cls} = {4'd12, 4'd0, 6'd5};
        // jirl b bl beq bne blt bge bltu bgeu
        17'b010011_???????????: {kind, alu, cls} = {4'd6, 4'd0, 6'd14};
        17'b010100_???????????: {kind, alu, cls} = {4'd9, 4'd15, 6'd13};
        17'b010101_???????????: {kind, alu, cls} = {4'd10, 4'd0, 6'd8};
        17'b010110_???????????: {kind, alu, cls} = {4'd7, 4'd15, 6'd12};
        17'b010111_???????????: {kind, alu, cls} = {4'd7, 4'd15, 6'd11};
        17'b011000_???????????: {kind, alu, cls} = {4'd8, 4'd15, 6'd7};
        17'b011001_???????????: {kind, alu, cls} = {4'd8, 4'd15, 6'd10};
        17'b011010_???????????: {kind, alu, cls} = {4'd8, 4'd15, 6'd6};
        17'b011011_???????????: {kind, alu, cls} = {4'd8, 4'd15, 6'd9};
        default: ;
    endcase

    d = '0;
    d.pc = bundle.pc;
    d.pred_pc = bundle.pred_pc;
    // out-of-range shifts give all zero for unknown words
    d.inst_class = inst_class_t'(37'd1 << cls);
    d.exe.alu_op = alu_op_t'(12'd1 << alu);

    d.regnums.r_addr1 = (kind == 4'd0) ? i[14:10] :
                        (kind inside {1, 2, 3, 6, 7, 8, 11, 12}) ? i[9:5] : 5'd0;
    d.regnums.r_addr2 = (kind == 4'd0) ? i[9:5] :
                        (kind inside {7, 8, 12}) ? i[4:0] : 5'd0;
    d.regnums.w_addr  = (kind inside {0, 1, 2, 3, 4, 5, 6, 11}) ? i[4:0] :
                        (kind == 4'd10) ? LINK_REG : 5'd0;

    case (kind)
        4'd1, 4'd11, 4'd12: d.imm = {{20{i[21]}}, i[21:10]};
        4'd2: d.imm = {20'd0, i[21:10]};
        4'd3: d.imm = {27'd0, i[14:10]};
        4'd4, 4'd5: d.imm = {i[24:5], 12'd0};
        4'd6, 4'd7, 4'd8: d.imm = {{14{i[25]}}, i[25:10], 2'b00};
        4'd9, 4'd10: d.imm = {{4{i[9]}}, i[9:0], i[25:10], 2'b00};
        default: d.imm = '0;
    endcase

    d.exe.src1_sel = (kind inside {5, 10}) ? SRC1_PC :
                     (kind inside {4, 8, 9}) ? SRC1_ZERO : SRC1_REGFILE;
    d.exe.src2_sel = (kind == 4'd10) ? SRC2_FOUR :
                     (kind inside {0, 7}) ? SRC2_REGFILE :
                     (kind inside {1, 2, 3, 4, 5, 6, 11, 12}) ? SRC2_IMM : SRC2_ZERO;

    // access size from inst[23:22]: 00 byte, 01 half, 10 word
    d.mem.en    = kind inside {11, 12};
    d.mem.we    = (kind == 4'd12);
    d.mem.width = !d.mem.en ? MEM_WORD :
                  (i[23:22] == 2'b00) ? MEM_BYTE :
                  (i[23:22] == 2'b01) ? MEM_HALF : MEM_WORD;

    d.wb.w_en        = kind inside {0, 1, 2, 3, 4, 5, 6, 10, 11};
    d.wb.from_mem    = (kind == 4'd11);
    d.wb.ready_stage = (kind == 4'd11) ? STAGE_MEM :
                       d.wb.w_en ? STAGE_EXE : STAGE_NONE;
    return d;
endfunction

`endif

// File: testbench/tb_predecode.sv
// random fetch bundles against the reference decode, with random output stalls
// single-entry stage assumed, so the expected queue never holds more than one item
module tb_predecode;
    import predecode_pkg::*;
    `include "predecode_model.svh"

    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 19;
    localparam int N_RANDOM   = 400;
    localparam int N_STREAM   = 100;
    // worst case a few stalled cycles per item, plus reset and drain
    localparam int WATCHDOG_CYCLES = (N_RANDOM + N_STREAM) * 8 + 200;

    localparam int MODE_IDLE   = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_STREAM = 2;
    localparam int MODE_DRAIN  = 3;

    // legal opcodes grouped by field width
    localparam logic [16:0] OPC17_LIST [14] = '{OPC_ADD_W, OPC_SUB_W, OPC_SLT, OPC_SLTU,
        OPC_NOR, OPC_AND, OPC_OR, OPC_XOR, OPC_SLL_W, OPC_SRL_W, OPC_SRA_W,
        OPC_SLLI_W, OPC_SRLI_W, OPC_SRAI_W};
    localparam logic [9:0] OPC10_LIST [12] = '{OPC_SLTI, OPC_SLTUI, OPC_ADDI_W, OPC_ANDI,
        OPC_ORI, OPC_XORI, OPC_LD_B, OPC_LD_H, OPC_LD_W, OPC_ST_B, OPC_ST_H, OPC_ST_W};
    localparam logic [6:0] OPC7_LIST [2] = '{OPC_LU12I_W, OPC_PCADDU12I};
    localparam logic [5:0] OPC6_LIST [9] = '{OPC_JIRL, OPC_B, OPC_BL, OPC_BEQ, OPC_BNE,
        OPC_BLT, OPC_BGE, OPC_BLTU, OPC_BGEU};

    logic          clk;
    logic          reset;
    logic          in_valid;
    logic          in_ready;
    fetch_bundle_t in_bundle;
    logic          out_valid;
    logic          out_ready;
    predecoded_t   out_data;

    // scoreboard state
    fetch_bundle_t expect_q [$];
    predecoded_t   prev_out_data;
    logic          pending;
    logic          last_in_fire;
    logic          stalled_last;
    logic          accepted_any;
    int unsigned   accept_count;

    predecode_stage UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bundle (in_bundle),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("MISMATCH at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first wrong value");
        end
    endtask

    // legal opcode with random fields, or a raw word that is mostly illegal
    function automatic fetch_bundle_t new_bundle();
        fetch_bundle_t b;
        int unsigned   k;
        logic [31:0]   r;
        r         = $urandom();
        k         = $urandom_range(36);
        b.pc      = $urandom() & 32'hffff_fffc;
        b.pred_pc = $urandom();
        if ($urandom_range(9) < 3)
            b.inst = r;
        else if (k < 14)
            b.inst = {OPC17_LIST[4'(k)], r[14:0]};
        else if (k < 26)
            b.inst = {OPC10_LIST[4'(k - 14)], r[21:0]};
        else if (k < 28)
            b.inst = {OPC7_LIST[1'(k - 26)], r[24:0]};
        else
            b.inst = {OPC6_LIST[4'(k - 28)], r[25:0]};
        return b;
    endfunction

    // drive on the falling edge, then check what the next rising edge will see
    task automatic run_cycle(input int mode);
        logic        in_fire;
        logic        out_fire;
        predecoded_t exp_d;
        @(negedge clk);
        // an offered bundle stays put until taken
        if (!pending)
        begin
            in_valid = (mode == MODE_STREAM) ? 1'b1 :
                       (mode == MODE_RANDOM) ? ($urandom_range(3) != 0) : 1'b0;
            if (in_valid)
                in_bundle = new_bundle();
        end
        out_ready = (mode == MODE_RANDOM) ? ($urandom_range(4) < 3) : 1'b1;
        #1;
        in_fire  = in_valid && in_ready;
        out_fire = out_valid && out_ready;

        if (!accepted_any)
            check_equal(64'(out_valid), 64'd0, "out_valid before first accept");
        if (last_in_fire)
            check_equal(64'(out_valid), 64'd1, "out_valid one cycle after accept");
        if (stalled_last)
        begin
            check_equal(64'(out_valid), 64'd1, "out_valid dropped during stall");
            check_equal(64'(out_data == prev_out_data), 64'd1, "out_data moved during stall");
        end
        if (out_valid && !out_ready)
            check_equal(64'(in_ready), 64'd0, "in_ready during stall");
        // an empty stage always takes a bundle
        if (!out_valid)
            check_equal(64'(in_ready), 64'd1, "in_ready while empty");
        if (mode == MODE_STREAM)
            check_equal(64'(in_ready), 64'd1, "in_ready with out_ready high");

        if (out_valid)
        begin
            check_equal(64'(expect_q.size()), 64'd1, "items held in the stage");
            exp_d = predecode_model(expect_q[0]);
            check_equal(64'(out_data.pc), 64'(exp_d.pc), "pc");
            check_equal(64'(out_data.pred_pc), 64'(exp_d.pred_pc), "pred_pc");
            check_equal(64'(out_data.inst_class), 64'(exp_d.inst_class), "inst_class");
            check_equal(64'(out_data.regnums), 64'(exp_d.regnums), "regnums");
            check_equal(64'(out_data.imm), 64'(exp_d.imm), "imm");
            check_equal(64'(out_data.exe), 64'(exp_d.exe), "exe controls");
            check_equal(64'(out_data.mem), 64'(exp_d.mem), "mem controls");
            check_equal(64'(out_data.wb), 64'(exp_d.wb), "wb controls");
        end
        else
            check_equal(64'(expect_q.size()), 64'd0, "item lost while stage empty");

        // held item leaves before the new one lands
        if (out_fire)
            void'(expect_q.pop_front());
        if (in_fire)
        begin
            expect_q.push_back(in_bundle);
            accept_count++;
            accepted_any = 1'b1;
        end
        last_in_fire  = in_fire;
        stalled_last  = out_valid && !out_ready;
        prev_out_data = out_data;
        pending       = in_valid && !in_fire;
    endtask

    ////////////////////////////////////////
    // main sequence

    initial
    begin
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_bundle     = '0;
        out_ready     = 1'b0;
        pending       = 1'b0;
        last_in_fire  = 1'b0;
        stalled_last  = 1'b0;
        accepted_any  = 1'b0;
        accept_count  = 0;
        prev_out_data = '0;
        void'($urandom(SEED));

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // a few empty cycles where out_valid must stay low
        repeat (4) run_cycle(MODE_IDLE);
        while (accept_count < N_RANDOM)
            run_cycle(MODE_RANDOM);
        // back-to-back bundles at one per cycle
        while (accept_count < N_RANDOM + N_STREAM)
            run_cycle(MODE_STREAM);
        while (expect_q.size() > 0)
            run_cycle(MODE_DRAIN);
        // drained stage must not present the last item again
        repeat (2) run_cycle(MODE_DRAIN);

        $display("Simulation finished: PASS");
        $finish;
    end

    ////////////////////////////////////////
    // watchdog

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired, the stage stopped accepting or returning items");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: verilog.f
+incdir+include
hw/predecode_pkg.sv
hw/inst_classifier.sv
hw/regnum_select.sv
hw/imm_gen.sv
hw/ctrl_gen.sv
hw/predecode_stage.sv
testbench/tb_predecode.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module tb_predecode -o tb_predecode
./obj_dir/tb_predecode 2>&1 | tee sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
